/* Bender.yml */
package:
  name: fp_unit

dependencies: {}

sources:
  # package first, the RTL modules import it
  - src/fp_pkg.sv
  - src/fpr.sv
  - src/fp_sign_inject.sv
  - src/fp_minmax.sv
  - src/fp_ctrl.sv
  - src/fp_unit_top.sv

  # self-checking testbench, top module fp_unit_tb
  - target: test
    files:
      - verification/fp_unit_tb.sv

/* src/fp_ctrl.sv */
/*
 fp unit control
 decodes one command per cycle, steers the datapaths, picks the result
 and registers writeback, result and store in the single pipeline stage
 */

`timescale 1ns/10ps
`default_nettype none

module fp_ctrl (
    input  wire                     clk_i,
    input  wire                     reset_i,

    input  fp_pkg::fp_cmd_t         cmd_i,

    // register file read side
    output logic [4:0]              raddr1_o,
    output logic [4:0]              raddr2_o,
    output logic [4:0]              raddr3_o,
    input  wire  [fp_pkg::FLEN-1:0] rdata1_i,
    input  wire  [fp_pkg::FLEN-1:0] rdata2_i,
    input  wire  [fp_pkg::FLEN-1:0] rdata3_i,

    // datapath controls and results
    output fp_pkg::fp_op_e          sgnj_op_o,
    output logic                    minmax_max_o,
    input  wire  [fp_pkg::FLEN-1:0] sgnj_res_i,
    input  wire  [fp_pkg::FLEN-1:0] minmax_res_i,

    output fp_pkg::fp_wb_t          wb_o,   // to fpr write port
    output fp_pkg::fp_res_t         res_o
);

    import fp_pkg::*;

    fp_wb_t  wb_d;
    fp_wb_t  wb_q;
    fp_res_t res_d;
    fp_res_t res_q;

    // read addresses straight from the command, no decode needed
    assign raddr1_o = cmd_i.rs1;
    assign raddr2_o = cmd_i.rs2;
    assign raddr3_o = cmd_i.rs3;

    assign sgnj_op_o    = cmd_i.op;
    assign minmax_max_o = (cmd_i.op == OP_FMAX);

    // stage inputs
    always_comb begin
        wb_d           = '0;
        res_d          = '0;
        wb_d.waddr     = cmd_i.rd;
        res_d.st_valid = cmd_i.valid && cmd_i.st_en;  // store rides with any op
        res_d.st_data  = rdata3_i;
        if (cmd_i.valid) begin
            case (cmd_i.op)
                OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: begin
                    res_d.valid = 1'b1;
                    res_d.data  = sgnj_res_i;
                    wb_d.we     = 1'b1;
                end
                OP_FMIN, OP_FMAX: begin
                    res_d.valid = 1'b1;
                    res_d.data  = minmax_res_i;
                    wb_d.we     = 1'b1;
                end
                OP_FMV_X_W: begin
                    res_d.valid  = 1'b1;
                    res_d.to_int = 1'b1;  // read out only, rd untouched
                    res_d.data   = rdata1_i;
                end
                OP_FMV_W_X: begin
                    res_d.valid = 1'b1;
                    res_d.data  = cmd_i.int_data;
                    wb_d.we     = 1'b1;
                end
                default: ;  // nop, store only
            endcase
        end
        wb_d.wdata = res_d.data;  // written value always equals reported data
    end

    // pipeline register, payload loads every cycle
    always_ff @(posedge clk_i) begin
        wb_q  <= wb_d;
        res_q <= res_d;
        if (reset_i) begin
            wb_q.we        <= 1'b0;
            res_q.valid    <= 1'b0;
            res_q.to_int   <= 1'b0;
            res_q.st_valid <= 1'b0;
        end
    end

    assign wb_o  = wb_q;
    assign res_o = res_q;

    // int-side moves never land in the fp register file
    a_no_we_on_to_int: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(wb_q.we && res_q.to_int)
    ) else $error("fp_ctrl write enable together with to_int");

    // a store pulse needs a result or a store request one cycle back
    a_store_origin: assert property (
        @(posedge clk_i) disable iff (reset_i)
        res_q.st_valid |-> (res_q.valid || $past(cmd_i.valid && cmd_i.st_en))
    ) else $error("fp_ctrl store pulse without request");

endmodule

`default_nettype wire

/* src/fp_minmax.sv */
/*
 min/max comparator for ieee single precision
 sign-magnitude compare, -0 below +0, one nan returns the other operand,
 two nans return the canonical nan
 */

`timescale 1ns/10ps
`default_nettype none

module fp_minmax (
    input  wire  [fp_pkg::FLEN-1:0] a_i,
    input  wire  [fp_pkg::FLEN-1:0] b_i,
    input  wire                     max_i,    // 0 = fmin, 1 = fmax
    output logic [fp_pkg::FLEN-1:0] result_o
);

    import fp_pkg::*;

    localparam int unsigned EXP_W = 8;
    localparam int unsigned MAN_W = 23;

    logic a_nan;
    logic b_nan;
    logic a_lt_b;  // a strictly below b

    // exponent all ones, fraction nonzero (snan and qnan alike)
    assign a_nan = (&a_i[MAN_W +: EXP_W]) && (|a_i[MAN_W-1:0]);
    assign b_nan = (&b_i[MAN_W +: EXP_W]) && (|b_i[MAN_W-1:0]);

    always_comb begin
        if (a_i[FLEN-1] != b_i[FLEN-1]) begin
            a_lt_b = a_i[FLEN-1];  // negative side smaller, covers -0 < +0
        end else if (!a_i[FLEN-1]) begin
            a_lt_b = a_i[FLEN-2:0] < b_i[FLEN-2:0];  // both positive
        end else begin
            a_lt_b = a_i[FLEN-2:0] > b_i[FLEN-2:0];  // both negative, order flips
        end
    end

    always_comb begin
        if (a_nan && b_nan) begin
            result_o = CANON_NAN;
        end else if (a_nan) begin
            result_o = b_i;
        end else if (b_nan) begin
            result_o = a_i;
        end else if (max_i) begin
            result_o = a_lt_b ? b_i : a_i;
        end else begin
            result_o = a_lt_b ? a_i : b_i;  // equal values, either is fine
        end
    end

endmodule

`default_nettype wire

/* src/fp_pkg.sv */
/*
 fp unit shared types
 single-precision register/move/compare unit: opcodes, command,
 writeback and result bundles
 */

`default_nettype none

package fp_pkg;

    localparam int unsigned FLEN = 32;  // fp register width, structs depend on it

    localparam logic [FLEN-1:0] CANON_NAN = 32'h7FC0_0000;  // canonical quiet nan

    // command opcodes, encoding fixed for the test data
    typedef enum logic [2:0] {
        OP_FSGNJ   = 3'd0,
        OP_FSGNJN  = 3'd1,
        OP_FSGNJX  = 3'd2,
        OP_FMIN    = 3'd3,
        OP_FMAX    = 3'd4,
        OP_FMV_X_W = 3'd5,  // fp reg -> int side
        OP_FMV_W_X = 3'd6,  // int side -> fp reg
        OP_NOP     = 3'd7   // store only when st_en set
    } fp_op_e;

    // one command per cycle from the issue side
    typedef struct packed {
        logic            valid;
        fp_op_e          op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rs3;       // store data source
        logic            st_en;     // drive rs3 onto store output
        logic [FLEN-1:0] int_data;  // operand for fmv.w.x
    } fp_cmd_t;

    // register file write port
    typedef struct packed {
        logic            we;
        logic [4:0]      waddr;
        logic [FLEN-1:0] wdata;
    } fp_wb_t;

    // registered output bundle, single-cycle pulses
    typedef struct packed {
        logic            valid;
        logic            to_int;    // data goes to int side (fmv.x.w)
        logic            st_valid;
        logic [FLEN-1:0] st_data;
        logic [FLEN-1:0] data;
    } fp_res_t;

endpackage

`default_nettype wire

/* src/fp_sign_inject.sv */
/*
 sign-injection datapath
 fsgnj / fsgnjn / fsgnjx: magnitude from a, sign built from b
 purely combinational
 */

`timescale 1ns/10ps
`default_nettype none

module fp_sign_inject (
    input  wire  [fp_pkg::FLEN-1:0] a_i,       // rs1, supplies bits 30:0
    input  wire  [fp_pkg::FLEN-1:0] b_i,       // rs2, supplies sign
    input  fp_pkg::fp_op_e          op_i,
    output logic [fp_pkg::FLEN-1:0] result_o
);

    import fp_pkg::*;

    logic sign_a;
    logic sign_b;
    logic sign_res;

    assign sign_a = a_i[FLEN-1];
    assign sign_b = b_i[FLEN-1];

    always_comb begin
        case (op_i)
            OP_FSGNJ:  sign_res = sign_b;           // copy
            OP_FSGNJN: sign_res = ~sign_b;          // negated copy
            OP_FSGNJX: sign_res = sign_a ^ sign_b;  // xor, fabs/fneg idioms
            default:   sign_res = sign_a;           // other ops, a passes through
        endcase
    end

    // exponent and fraction untouched, no nan canonicalization
    assign result_o = {sign_res, a_i[FLEN-2:0]};

endmodule

`default_nettype wire

/* src/fp_unit_top.sv */
/*
 fp register and move/compare unit, top level
 control, register file and the two datapaths, one cycle latency
 */

`timescale 1ns/10ps
`default_nettype none

module fp_unit_top #(
    parameter int unsigned NUM_FREGS = 32  // 16 also supported
) (
    input  wire              clk_i,
    input  wire              reset_i,
    input  fp_pkg::fp_cmd_t  cmd_i,
    output fp_pkg::fp_res_t  res_o
);

    import fp_pkg::*;

    logic [4:0]      raddr1;
    logic [4:0]      raddr2;
    logic [4:0]      raddr3;
    logic [FLEN-1:0] rdata1;
    logic [FLEN-1:0] rdata2;
    logic [FLEN-1:0] rdata3;
    fp_op_e          sgnj_op;
    logic            minmax_max;
    logic [FLEN-1:0] sgnj_res;
    logic [FLEN-1:0] minmax_res;
    fp_wb_t          wb;  // internal writeback, not exported

    fp_ctrl fp_ctrl_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cmd_i        (cmd_i),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .raddr3_o     (raddr3),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .rdata3_i     (rdata3),
        .sgnj_op_o    (sgnj_op),
        .minmax_max_o (minmax_max),
        .sgnj_res_i   (sgnj_res),
        .minmax_res_i (minmax_res),
        .wb_o         (wb),
        .res_o        (res_o)
    );

    fpr #(
        .NUM_FREGS (NUM_FREGS)
    ) fpr_inst (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wb_i     (wb),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .raddr3_i (raddr3),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .rdata3_o (rdata3)
    );

    fp_sign_inject fp_sign_inject_inst (
        .a_i      (rdata1),
        .b_i      (rdata2),
        .op_i     (sgnj_op),
        .result_o (sgnj_res)
    );

    fp_minmax fp_minmax_inst (
        .a_i      (rdata1),
        .b_i      (rdata2),
        .max_i    (minmax_max),
        .result_o (minmax_res)
    );

endmodule

`default_nettype wire

/* src/fpr.sv */
/*
 floating-point register file
 one write port, three combinational read ports, write-to-read bypass
 registers clear synchronously on reset
 */

`timescale 1ns/10ps
`default_nettype none

module fpr #(
    parameter int unsigned NUM_FREGS = 32
) (
    input  wire                     clk_i,
    input  wire                     reset_i,

    input  fp_pkg::fp_wb_t          wb_i,      // write port from ctrl stage

    input  wire  [4:0]              raddr1_i,  // rs1
    input  wire  [4:0]              raddr2_i,  // rs2
    input  wire  [4:0]              raddr3_i,  // rs3, store data

    output logic [fp_pkg::FLEN-1:0] rdata1_o,
    output logic [fp_pkg::FLEN-1:0] rdata2_o,
    output logic [fp_pkg::FLEN-1:0] rdata3_o
);

    import fp_pkg::*;

    logic [FLEN-1:0]      fregs [NUM_FREGS];
    logic [NUM_FREGS-1:0] reg_we;  // per-register load enable

    // one flop bank per register, like the int regfile
    genvar g;
    generate
        for (g = 0; g < NUM_FREGS; g++) begin : gen_fregs
            assign reg_we[g] = wb_i.we && (wb_i.waddr == g);

            always_ff @(posedge clk_i) begin
                if (reset_i) begin
                    fregs[g] <= '0;
                end else if (reg_we[g]) begin
                    fregs[g] <= wb_i.wdata;
                end
            end
        end
    endgenerate

    // bypass first, then stored value
    // addresses past NUM_FREGS read as zero
    function automatic logic [FLEN-1:0] read_port(input logic [4:0] addr);
        logic [FLEN-1:0] val;
        val = '0;
        if (wb_i.we && (wb_i.waddr == addr)) begin
            val = wb_i.wdata;  // value written this edge
        end else if (addr < NUM_FREGS) begin
            val = fregs[addr];
        end
        return val;
    endfunction

    always_comb rdata1_o = read_port(raddr1_i);
    always_comb rdata2_o = read_port(raddr2_i);
    always_comb rdata3_o = read_port(raddr3_i);

    // ctrl must never target a register that does not exist
    // (matters when built with 16 registers)
    a_waddr_in_range: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wb_i.we |-> (wb_i.waddr < NUM_FREGS)
    ) else $error("fpr write to address %0d, only %0d registers", wb_i.waddr, NUM_FREGS);

endmodule

`default_nettype wire

/* tb.f */
src/fp_pkg.sv
src/fpr.sv
src/fp_sign_inject.sv
src/fp_minmax.sv
src/fp_ctrl.sv
src/fp_unit_top.sv
verification/fp_unit_tb.sv

/* verification/fp_unit_tb.sv */
/*
 fp unit testbench
 streams commands from the test data file one per cycle, checks each
 registered result a cycle later, then runs random fmin/fmax pairs
 */

`timescale 1ns/10ps
`default_nettype none

module fp_unit_tb;

    import fp_pkg::*;

    localparam int RESET_TIMEOUT  = 32;  // cycles
    localparam int RESULT_TIMEOUT = 8;
    localparam int NUM_RANDOM     = 40;
    localparam int NUM_REGS       = 32;

    logic    clk;
    logic    reset;
    fp_cmd_t cmd;
    fp_res_t res;

    integer  seed = 31854;
    logic    have_pending;       // a command is in flight
    fp_res_t pend_exp;
    string   pend_tag;

    fp_unit_top #(
        .NUM_FREGS (NUM_REGS)
    ) fp_unit_top_inst (
        .clk_i   (clk),
        .reset_i (reset),
        .cmd_i   (cmd),
        .res_o   (res)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

    task automatic fail_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string tag,
                                   input logic [31:0] exp, input logic [31:0] got);
        $display("[ERROR] %s expected 0x%08h got 0x%08h (%s)", name, exp, got, tag);
        fail_run();
    endtask

    // nan has exponent all ones and fraction not zero
    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
    endfunction

    // maps a float onto an unsigned scale where -0 lands just below +0
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [31:0] expected_minmax(input logic [31:0] a,
                                                    input logic [31:0] b,
                                                    input logic        is_max);
        if (is_nan(a) && is_nan(b)) return CANON_NAN;
        if (is_nan(a)) return b;
        if (is_nan(b)) return a;
        if (is_max) return (order_key(a) >= order_key(b)) ? a : b;
        return (order_key(a) <= order_key(b)) ? a : b;
    endfunction

    // distinct per register, every address bit shows in both halves
    function automatic logic [31:0] reg_pattern(input logic [4:0] idx);
        return {8'ha5, 3'b000, idx, 8'h3c, 3'b000, ~idx};
    endfunction

    // operand mix with zeros, nans and infinities
    task automatic random_operand(output logic [31:0] v);
        logic [31:0] raw;
        integer      pick;
        raw  = $random(seed);
        pick = $random(seed);
        case (pick[2:0])
            3'd0:    v = 32'h0000_0000;
            3'd1:    v = 32'h8000_0000;
            3'd2:    v = {raw[31], 8'hff, 1'b1, raw[21:0]};        // quiet nan
            3'd3:    v = {raw[31], 8'hff, 1'b0, raw[21:1], 1'b1};  // signalling nan
            3'd4:    v = {raw[31], 8'hff, 23'h0};                  // infinity
            default: v = raw;
        endcase
    endtask

    task automatic compare_result(input fp_res_t exp, input string tag);
        assert (res.valid === exp.valid)
            else report_mismatch("res_o.valid", tag, exp.valid, res.valid);
        assert (res.st_valid === exp.st_valid)
            else report_mismatch("res_o.st_valid", tag, exp.st_valid, res.st_valid);
        assert (res.to_int === exp.to_int)
            else report_mismatch("res_o.to_int", tag, exp.to_int, res.to_int);
        if (exp.valid) begin
            assert (res.data === exp.data)
                else report_mismatch("res_o.data", tag, exp.data, res.data);
        end
        if (exp.st_valid) begin
            assert (res.st_data === exp.st_data)
                else report_mismatch("res_o.st_data", tag, exp.st_data, res.st_data);
        end
    endtask

    // waits for the pulse of the command in flight and one cycle for idle ones
    task automatic check_pending();
        int   cycles;
        logic waiting;
        logic expect_out;
        cycles     = 0;
        waiting    = 1'b1;
        expect_out = pend_exp.valid || pend_exp.st_valid;
        while (waiting) begin
            @(negedge clk);
            cycles++;
            if (!expect_out || res.valid || res.st_valid) begin
                waiting = 1'b0;
            end else if (cycles >= RESULT_TIMEOUT) begin
                $display("no result appeared for %s within %0d cycles", pend_tag, cycles);
                fail_run();
            end
        end
        compare_result(pend_exp, pend_tag);
    endtask

    // drives one command and checks the one before it
    task automatic step(input fp_cmd_t c, input fp_res_t exp, input string tag);
        @(posedge clk);
        cmd <= c;
        if (have_pending) check_pending();
        pend_exp     = exp;
        pend_tag     = tag;
        have_pending = 1'b1;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset) begin
            @(negedge clk);
            cycles++;
            if (cycles >= RESET_TIMEOUT) begin
                $display("reset was not released after %0d cycles", cycles);
                fail_run();
            end
        end
    endtask

    initial begin
        integer      fd;
        integer      rc;
        integer      n;
        int          line_no;
        int          num_cmds;
        string       line;
        logic [31:0] op;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] rs3;
        logic [31:0] st_en;
        logic [31:0] int_data;
        logic [31:0] ev;
        logic [31:0] eti;
        logic [31:0] ed;
        logic [31:0] esv;
        logic [31:0] esd;
        logic [31:0] a;
        logic [31:0] b;
        integer      r;
        fp_cmd_t     c;
        fp_res_t     e;

        cmd          = '0;
        have_pending = 1'b0;
        wait_reset_release();
        assert (!res.valid)
            else report_mismatch("res_o.valid", "after reset", 32'h0, res.valid);
        assert (!res.st_valid)
            else report_mismatch("res_o.st_valid", "after reset", 32'h0, res.st_valid);

        fd = $fopen("verification/fp_unit_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/fp_unit_tests.txt");
            fail_run();
        end
        line_no  = 0;
        num_cmds = 0;
        while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            line_no++;
            if (rc > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", op, rd, rs1,
                            rs2, rs3, st_en, int_data, ev, eti, ed, esv, esd);
                if (n == 12) begin
                    c          = '0;
                    c.valid    = 1'b1;
                    c.op       = fp_op_e'(op[2:0]);
                    c.rd       = rd[4:0];
                    c.rs1      = rs1[4:0];
                    c.rs2      = rs2[4:0];
                    c.rs3      = rs3[4:0];
                    c.st_en    = st_en[0];
                    c.int_data = int_data;
                    e          = '0;
                    e.valid    = ev[0];
                    e.to_int   = eti[0];
                    e.data     = ed;
                    e.st_valid = esv[0];
                    e.st_data  = esd;
                    step(c, e, $sformatf("line %0d", line_no));
                    num_cmds++;
                end else if (n > 0) begin
                    $display("test data line %0d has %0d fields instead of 12", line_no, n);
                    fail_run();
                end
            end
        end
        $fclose(fd);
        assert (num_cmds > 0) else begin
            $display("test data file held no commands");
            fail_run();
        end

        // every register loaded and read back in the next cycle through the bypass
        for (int i = 0; i < NUM_REGS; i++) begin
            c = '0;
            c.valid    = 1'b1;
            c.op       = OP_FMV_W_X;
            c.rd       = i[4:0];
            c.int_data = reg_pattern(i[4:0]);
            e = '0;
            e.valid = 1'b1;
            e.data  = reg_pattern(i[4:0]);
            step(c, e, $sformatf("load f%0d", i));

            c.op     = OP_FMV_X_W;
            c.rs1    = i[4:0];
            e.to_int = 1'b1;
            step(c, e, $sformatf("bypass read f%0d", i));
        end

        // stored values, aliased registers would show up here
        for (int i = 0; i < NUM_REGS; i++) begin
            c = '0;
            c.valid = 1'b1;
            c.op    = OP_FMV_X_W;
            c.rs1   = i[4:0];
            c.rs3   = ~i[4:0];  // mirrored register on the store port
            c.st_en = 1'b1;
            e = '0;
            e.valid    = 1'b1;
            e.to_int   = 1'b1;
            e.data     = reg_pattern(i[4:0]);
            e.st_valid = 1'b1;
            e.st_data  = reg_pattern(~i[4:0]);
            step(c, e, $sformatf("stored read f%0d", i));
        end

        // random pairs go through f20 and f21 with the result in f22
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_operand(a);
            random_operand(b);
            r = $random(seed);

            c = '0;
            c.valid    = 1'b1;
            c.op       = OP_FMV_W_X;
            c.rd       = 5'd20;
            c.int_data = a;
            e = '0;
            e.valid = 1'b1;
            e.data  = a;
            step(c, e, $sformatf("random pair %0d load a", i));

            c.rd       = 5'd21;
            c.int_data = b;
            e.data     = b;
            step(c, e, $sformatf("random pair %0d load b", i));

            // store of f20 rides along
            c = '0;
            c.valid = 1'b1;
            c.op    = r[0] ? OP_FMAX : OP_FMIN;
            c.rd    = 5'd22;
            c.rs1   = 5'd20;
            c.rs2   = 5'd21;  // just written so it comes through the bypass
            c.rs3   = 5'd20;
            c.st_en = 1'b1;
            e = '0;
            e.valid    = 1'b1;
            e.data     = expected_minmax(a, b, r[0]);
            e.st_valid = 1'b1;
            e.st_data  = a;
            step(c, e, $sformatf("random pair %0d a=%08h b=%08h max=%0d", i, a, b, r[0]));
        end

        // two idle cycles flush the last result and check silence
        step('0, '0, "drain 0");
        step('0, '0, "drain 1");
        check_pending();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/fp_unit_tests.txt */
# op rd rs1 rs2 rs3 st_en int_data | exp: valid to_int data st_valid st_data (all hex)
# op: 0 fsgnj 1 fsgnjn 2 fsgnjx 3 fmin 4 fmax 5 fmv.x.w 6 fmv.w.x 7 nop
5 00 01 00 00 0 00000000 1 1 00000000 0 00000000
5 00 1f 00 00 0 00000000 1 1 00000000 0 00000000
7 00 00 00 00 0 00000000 0 0 00000000 0 00000000
7 00 00 00 00 0 00000000 0 0 00000000 0 00000000
5 00 10 00 00 1 00000000 1 1 00000000 1 00000000
6 01 00 00 00 0 3f800000 1 0 3f800000 0 00000000
5 00 01 00 00 0 00000000 1 1 3f800000 0 00000000
6 02 00 00 00 0 c0400000 1 0 c0400000 0 00000000
5 00 02 00 00 0 00000000 1 1 c0400000 0 00000000
6 1f 00 00 00 0 12345678 1 0 12345678 0 00000000
7 00 00 00 00 0 00000000 0 0 00000000 0 00000000
5 00 1f 00 00 0 00000000 1 1 12345678 0 00000000
5 00 01 00 00 0 00000000 1 1 3f800000 0 00000000
6 03 00 00 00 0 7f800000 1 0 7f800000 0 00000000
6 04 00 00 00 0 80000000 1 0 80000000 0 00000000
6 05 00 00 00 0 7fc00001 1 0 7fc00001 0 00000000
6 06 00 00 00 0 ff800001 1 0 ff800001 0 00000000
6 07 00 00 00 0 40490fdb 1 0 40490fdb 0 00000000
0 08 01 02 00 0 00000000 1 0 bf800000 0 00000000
5 00 08 00 00 0 00000000 1 1 bf800000 0 00000000
1 09 02 02 00 0 00000000 1 0 40400000 0 00000000
2 0a 08 02 00 0 00000000 1 0 3f800000 0 00000000
5 00 09 00 00 0 00000000 1 1 40400000 0 00000000
5 00 0a 00 00 0 00000000 1 1 3f800000 0 00000000
0 0b 06 00 00 0 00000000 1 0 7f800001 0 00000000
3 0c 01 02 00 0 00000000 1 0 c0400000 0 00000000
4 0d 01 02 00 0 00000000 1 0 3f800000 0 00000000
3 0e 00 04 00 0 00000000 1 0 80000000 0 00000000
4 0e 04 00 00 0 00000000 1 0 00000000 0 00000000
3 0f 05 01 00 0 00000000 1 0 3f800000 0 00000000
4 0f 02 06 00 0 00000000 1 0 c0400000 0 00000000
3 10 05 06 00 0 00000000 1 0 7fc00000 0 00000000
4 10 06 05 00 0 00000000 1 0 7fc00000 0 00000000
4 11 03 07 00 0 00000000 1 0 7f800000 0 00000000
3 11 02 08 00 0 00000000 1 0 c0400000 0 00000000
5 00 10 00 00 0 00000000 1 1 7fc00000 0 00000000
6 12 00 00 01 1 cafef00d 1 0 cafef00d 1 3f800000
7 00 00 00 12 1 00000000 0 0 00000000 1 cafef00d
3 13 01 02 12 1 00000000 1 0 c0400000 1 cafef00d
5 00 13 00 13 1 00000000 1 1 c0400000 1 c0400000
7 00 00 00 00 0 00000000 0 0 00000000 0 00000000
